//--- verilog/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data path width of the RV64 integer pipeline.
`define EX_XLEN   64

// Immediate as delivered by decode before the stage sign-extends it.
`define EX_IMM_W  32

// Destination register address width.
`define EX_REG_W  5

// CSR address width.
`define EX_CSR_W  12

// Width of the ALU control word.
`define EX_CTRL_W 6

`endif

//--- verilog/ex_pkg.sv
package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10    // LUI and CSR writes.
    } alu_op_t;

    typedef enum logic [1:0] {
        MD_MUL    = 2'd0,
        MD_MULH   = 2'd1,
        MD_MULHSU = 2'd2,
        MD_MULHU  = 2'd3
    } md_op_t;

    typedef struct packed {
        logic    muldiv;    // Bit 5 picks the view in both layouts.
        logic    word;
        alu_op_t op;
    } alu_view_t;

    typedef struct packed {
        logic   muldiv;
        logic   word;
        logic   rsvd;
        logic   div;        // Division and remainder are not computed.
        md_op_t op;
    } md_view_t;

    typedef union packed {
        alu_view_t alu;
        md_view_t  md;
    } alu_ctrl_u;

    // Decode pairs BLT and BGE with SLT or SLTU and pairs BEQ and BNE with SUB.
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_JAL  = 3'd1,
        BR_JALR = 3'd2,
        BR_BEQ  = 3'd4,
        BR_BNE  = 3'd5,
        BR_BLT  = 3'd6,
        BR_BGE  = 3'd7
    } branch_t;

    typedef enum logic [1:0] {
        BSRC_SRC2 = 2'd0,
        BSRC_FOUR = 2'd1,
        BSRC_IMM  = 2'd2,
        BSRC_CSR  = 2'd3
    } bsrc_t;

endpackage

//--- verilog/ex_unit_if.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

interface ex_unit_if (
    input logic clk,
    input logic rst
);
    logic [`EX_XLEN-1:0] op_a;
    logic [`EX_XLEN-1:0] op_b;
    logic [`EX_XLEN-1:0] src1;
    logic [`EX_XLEN-1:0] src2;
    ex_pkg::alu_ctrl_u   ctrl;
    logic                valid;         // Stage register holds a live instruction.
    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_zero;
    logic [`EX_XLEN-1:0] md_result;
    logic                md_error;

    modport stage (
        input  clk, rst, alu_result, alu_zero, md_result, md_error,
        output op_a, op_b, src1, src2, ctrl, valid
    );

    modport alu (
        input  clk, rst, op_a, op_b, ctrl, valid,
        output alu_result, alu_zero
    );

    modport muldiv (
        input  clk, rst, src1, src2, ctrl, valid,
        output md_result, md_error
    );

endinterface

//--- verilog/ex_alu.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_alu (
    ex_unit_if.alu u
);
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [31:0]         a_w;
    logic [31:0]         b_w;
    logic [5:0]          shamt;
    logic [4:0]          shamt_w;
    logic [`EX_XLEN-1:0] res_d;
    logic [31:0]         res_w;

    assign a       = u.op_a;
    assign b       = u.op_b;
    assign a_w     = u.op_a[31:0];
    assign b_w     = u.op_b[31:0];
    assign shamt   = u.op_b[5:0];
    assign shamt_w = u.op_b[4:0];

    always_comb begin
        res_d = '0;
        res_w = '0;
        case (u.ctrl.alu.op)
            ex_pkg::ALU_ADD: begin
                res_d = a + b;
                res_w = a_w + b_w;
            end
            ex_pkg::ALU_SUB: begin
                res_d = a - b;
                res_w = a_w - b_w;
            end
            ex_pkg::ALU_SLL: begin
                res_d = a << shamt;
                res_w = a_w << shamt_w;
            end
            ex_pkg::ALU_SLT: begin
                res_d = {{(`EX_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                res_w = res_d[31:0];
            end
            ex_pkg::ALU_SLTU: begin
                res_d = {{(`EX_XLEN-1){1'b0}}, a < b};
                res_w = res_d[31:0];
            end
            ex_pkg::ALU_XOR: begin
                res_d = a ^ b;
                res_w = res_d[31:0];
            end
            ex_pkg::ALU_SRL: begin
                res_d = a >> shamt;
                res_w = a_w >> shamt_w;
            end
            ex_pkg::ALU_SRA: begin
                res_d = $signed(a) >>> shamt;
                res_w = $signed(a_w) >>> shamt_w;
            end
            ex_pkg::ALU_OR: begin
                res_d = a | b;
                res_w = res_d[31:0];
            end
            ex_pkg::ALU_AND: begin
                res_d = a & b;
                res_w = res_d[31:0];
            end
            ex_pkg::ALU_PASS_B: begin
                res_d = b;
                res_w = b_w;
            end
            default: begin
                res_d = '0;
                res_w = '0;
            end
        endcase
    end

    assign u.alu_result = u.ctrl.alu.word ? {{32{res_w[31]}}, res_w} : res_d;
    assign u.alu_zero   = (u.alu_result == '0);   // BEQ and BNE resolve on this flag.

    // Decode must not hand a live ALU instruction an unused opcode.
    a_alu_op_legal: assert property (
        @(posedge u.clk) disable iff (u.rst)
        (u.valid && !u.ctrl.alu.muldiv) |-> (u.ctrl.alu.op <= ex_pkg::ALU_PASS_B)
    );

endmodule

//--- verilog/ex_muldiv.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_muldiv (
    ex_unit_if.muldiv u
);
    logic                  sign_a;
    logic                  sign_b;
    logic [2*`EX_XLEN-1:0] a_ext;
    logic [2*`EX_XLEN-1:0] b_ext;
    logic [2*`EX_XLEN-1:0] prod;
    logic [`EX_XLEN-1:0]   lo;

    // MULHSU treats only the first operand as signed.
    always_comb begin
        case (u.ctrl.md.op)
            ex_pkg::MD_MULH: begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            ex_pkg::MD_MULHSU: begin
                sign_a = 1'b1;
                sign_b = 1'b0;
            end
            default: begin
                sign_a = 1'b0;
                sign_b = 1'b0;
            end
        endcase
    end

    assign a_ext = {{`EX_XLEN{sign_a & u.src1[`EX_XLEN-1]}}, u.src1};
    assign b_ext = {{`EX_XLEN{sign_b & u.src2[`EX_XLEN-1]}}, u.src2};
    assign prod  = a_ext * b_ext;    // Low 128 bits are exact for every sign mix.

    assign lo = u.ctrl.md.word ? {{32{prod[31]}}, prod[31:0]} : prod[`EX_XLEN-1:0];

    always_comb begin
        if (u.ctrl.md.div) begin
            u.md_result = '0;
        end else if (u.ctrl.md.op == ex_pkg::MD_MUL) begin
            u.md_result = lo;
        end else begin
            u.md_result = prod[2*`EX_XLEN-1:`EX_XLEN];
        end
    end

    assign u.md_error = u.ctrl.md.div;    // Division is flagged, not computed.

    // Decode leaves the reserved bit clear in a live multiply or divide.
    a_rsvd_clear: assert property (
        @(posedge u.clk) disable iff (u.rst)
        (u.valid && u.ctrl.md.muldiv) |-> !u.ctrl.md.rsvd
    );

endmodule

//--- verilog/ex_next_pc.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_next_pc (
    input  logic [`EX_XLEN-1:0] pc,
    input  logic [`EX_XLEN-1:0] src1,
    input  logic [`EX_XLEN-1:0] imm,
    input  logic                zero,
    input  logic                result_lsb,
    input  ex_pkg::branch_t     branch,
    output logic [`EX_XLEN-1:0] next_pc,
    output logic                taken
);
    logic [`EX_XLEN-1:0] target;
    logic [`EX_XLEN-1:0] jalr_sum;

    always_comb begin
        case (branch)
            ex_pkg::BR_JAL:  taken = 1'b1;
            ex_pkg::BR_JALR: taken = 1'b1;
            ex_pkg::BR_BEQ:  taken = zero;
            ex_pkg::BR_BNE:  taken = !zero;
            ex_pkg::BR_BLT:  taken = result_lsb;       // SLT or SLTU result.
            ex_pkg::BR_BGE:  taken = !result_lsb;
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum = src1 + imm;
    assign target   = (branch == ex_pkg::BR_JALR) ? {jalr_sum[`EX_XLEN-1:1], 1'b0} : pc + imm;
    assign next_pc  = taken ? target : pc + `EX_XLEN'd4;

    // Encoding 3 is a hole in the branch field.
    always_comb begin
        a_branch_legal: assert final (branch != ex_pkg::branch_t'(3'd3));
    end

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  block,
    input  logic                  valid_in,
    input  logic                  error_in,
    input  logic                  raise_intr,
    input  logic [`EX_XLEN-1:0]   src1_in,
    input  logic [`EX_XLEN-1:0]   src2_in,
    input  logic [`EX_XLEN-1:0]   csr_data_in,
    input  logic [`EX_XLEN-1:0]   pc_in,
    input  logic [`EX_IMM_W-1:0]  imm_in,
    input  logic [`EX_CSR_W-1:0]  csr_addr_in,
    input  logic [`EX_REG_W-1:0]  rd_in,
    input  logic                  asrc_pc_in,
    input  ex_pkg::bsrc_t         bsrc_in,
    input  ex_pkg::alu_ctrl_u     alu_ctrl_in,
    input  ex_pkg::branch_t       branch_in,
    input  logic [2:0]            mem_op_in,
    input  logic                  mem_rd_in,
    input  logic                  mem_wr_in,
    input  logic                  reg_wr_in,
    input  logic                  csr_in,
    input  logic                  ecall_in,
    input  logic                  mret_in,
    input  logic                  done_in,
    output logic                  valid,
    output logic [`EX_XLEN-1:0]   result,
    output logic [`EX_XLEN-1:0]   next_pc,
    output logic [`EX_XLEN-1:0]   pc,
    output logic [`EX_XLEN-1:0]   store_data,
    output logic [`EX_CSR_W-1:0]  csr_addr,
    output logic [`EX_REG_W-1:0]  rd,
    output logic [2:0]            mem_op,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic                  reg_wr,
    output logic                  csr,
    output logic                  ecall,
    output logic                  mret,
    output logic                  done,
    output logic                  is_ex,
    output logic                  is_jmp,
    output logic                  error
);
    logic                 valid_q;
    logic                 error_q;
    logic [`EX_XLEN-1:0]  src1_q;
    logic [`EX_XLEN-1:0]  src2_q;
    logic [`EX_XLEN-1:0]  csr_data_q;
    logic [`EX_XLEN-1:0]  pc_q;
    logic [`EX_IMM_W-1:0] imm_q;
    logic [`EX_CSR_W-1:0] csr_addr_q;
    logic [`EX_REG_W-1:0] rd_q;
    logic                 asrc_pc_q;
    ex_pkg::bsrc_t        bsrc_q;
    ex_pkg::alu_ctrl_u    ctrl_q;
    ex_pkg::branch_t      branch_q;
    logic [2:0]           mem_op_q;
    logic                 mem_rd_q;
    logic                 mem_wr_q;
    logic                 reg_wr_q;
    logic                 csr_q;
    logic                 ecall_q;
    logic                 mret_q;
    logic                 done_q;
    logic [`EX_XLEN-1:0]  imm_ext;
    logic                 taken;
    logic                 is_mul;

    ex_unit_if u (.clk(clk), .rst(rst));

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!block) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            error_q    <= error_in;
            src1_q     <= src1_in;
            src2_q     <= src2_in;
            csr_data_q <= csr_data_in;
            pc_q       <= pc_in;
            imm_q      <= imm_in;
            csr_addr_q <= csr_addr_in;
            rd_q       <= rd_in;
            asrc_pc_q  <= asrc_pc_in;
            bsrc_q     <= bsrc_in;
            ctrl_q     <= alu_ctrl_in;
            branch_q   <= branch_in;
            mem_op_q   <= mem_op_in;
            mem_rd_q   <= mem_rd_in;
            mem_wr_q   <= mem_wr_in;
            reg_wr_q   <= reg_wr_in;
            csr_q      <= csr_in;
            ecall_q    <= ecall_in;
            mret_q     <= mret_in;
            done_q     <= done_in;
        end
    end

    assign imm_ext = {{(`EX_XLEN-`EX_IMM_W){imm_q[`EX_IMM_W-1]}}, imm_q};

    assign u.op_a  = asrc_pc_q ? pc_q : src1_q;
    assign u.src1  = src1_q;
    assign u.src2  = src2_q;
    assign u.ctrl  = ctrl_q;
    assign u.valid = valid_q;

    always_comb begin
        case (bsrc_q)
            ex_pkg::BSRC_SRC2: u.op_b = src2_q;
            ex_pkg::BSRC_FOUR: u.op_b = `EX_XLEN'd4;
            ex_pkg::BSRC_IMM:  u.op_b = imm_ext;
            default:           u.op_b = csr_data_q;
        endcase
    end

    ex_alu alu0 (.u(u.alu));

    ex_muldiv muldiv0 (.u(u.muldiv));

    ex_next_pc next_pc0 (
        .pc         (pc_q),
        .src1       (src1_q),
        .imm        (imm_ext),
        .zero       (u.alu_zero),
        .result_lsb (u.alu_result[0]),
        .branch     (branch_q),
        .next_pc    (next_pc),
        .taken      (taken)
    );

    assign is_mul = ctrl_q.md.muldiv && !ctrl_q.md.div;

    assign result = ctrl_q.alu.muldiv ? u.md_result : u.alu_result;
    assign valid  = valid_q && (ecall_q || !raise_intr);    // An ecall survives the interrupt.
    assign is_ex  = !mem_rd_q && !is_mul;
    assign is_jmp = (taken || csr_q) && valid_q;            // CSR access flushes the front end.
    assign error  = error_q || (ctrl_q.md.muldiv && u.md_error);

    assign pc         = pc_q;
    assign store_data = src2_q;
    assign csr_addr   = csr_addr_q;
    assign rd         = rd_q;
    assign mem_op     = mem_op_q;
    assign mem_rd     = mem_rd_q;
    assign mem_wr     = mem_wr_q;
    assign reg_wr     = reg_wr_q;
    assign csr        = csr_q;
    assign ecall      = ecall_q;
    assign mret       = mret_q;
    assign done       = done_q;

    a_valid_after_rst: assert property (@(posedge clk) rst |=> !valid);

    // The memory stage relies on a frozen instruction while it stalls us.
    a_hold_on_block: assert property (
        @(posedge clk) block |=> ($stable(pc) && $stable(rd))
    );

endmodule

//--- verilog/ex_top.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  block,
    input  logic                  valid_in,
    input  logic                  error_in,
    input  logic                  raise_intr,
    input  logic [`EX_XLEN-1:0]   src1_in,
    input  logic [`EX_XLEN-1:0]   src2_in,
    input  logic [`EX_XLEN-1:0]   csr_data_in,
    input  logic [`EX_XLEN-1:0]   pc_in,
    input  logic [`EX_IMM_W-1:0]  imm_in,
    input  logic [`EX_CSR_W-1:0]  csr_addr_in,
    input  logic [`EX_REG_W-1:0]  rd_in,
    input  logic                  asrc_pc_in,
    input  ex_pkg::bsrc_t         bsrc_in,
    input  logic [`EX_CTRL_W-1:0] alu_ctrl_in,     // Raw control word from decode.
    input  ex_pkg::branch_t       branch_in,
    input  logic [2:0]            mem_op_in,
    input  logic                  mem_rd_in,
    input  logic                  mem_wr_in,
    input  logic                  reg_wr_in,
    input  logic                  csr_in,
    input  logic                  ecall_in,
    input  logic                  mret_in,
    input  logic                  done_in,
    output logic                  valid,
    output logic [`EX_XLEN-1:0]   result,
    output logic [`EX_XLEN-1:0]   next_pc,
    output logic [`EX_XLEN-1:0]   pc,
    output logic [`EX_XLEN-1:0]   store_data,
    output logic [`EX_CSR_W-1:0]  csr_addr,
    output logic [`EX_REG_W-1:0]  rd,
    output logic [2:0]            mem_op,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic                  reg_wr,
    output logic                  csr,
    output logic                  ecall,
    output logic                  mret,
    output logic                  done,
    output logic                  is_ex,
    output logic                  is_jmp,
    output logic                  error
);
    ex_pkg::alu_ctrl_u alu_ctrl;

    assign alu_ctrl = alu_ctrl_in;

    ex_stage stage0 (
        .clk, .rst, .block, .valid_in, .error_in, .raise_intr,
        .src1_in, .src2_in, .csr_data_in, .pc_in, .imm_in, .csr_addr_in, .rd_in,
        .asrc_pc_in, .bsrc_in, .alu_ctrl_in(alu_ctrl), .branch_in, .mem_op_in,
        .mem_rd_in, .mem_wr_in, .reg_wr_in, .csr_in, .ecall_in, .mret_in, .done_in,
        .valid, .result, .next_pc, .pc, .store_data, .csr_addr, .rd, .mem_op,
        .mem_rd, .mem_wr, .reg_wr, .csr, .ecall, .mret, .done,
        .is_ex, .is_jmp, .error
    );

endmodule

//--- tb/ex_tb.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_tb;
    logic                  clk;
    logic                  rst;
    logic                  block;
    logic                  valid_in;
    logic                  error_in;
    logic                  raise_intr;
    logic [`EX_XLEN-1:0]   src1_in;
    logic [`EX_XLEN-1:0]   src2_in;
    logic [`EX_XLEN-1:0]   csr_data_in;
    logic [`EX_XLEN-1:0]   pc_in;
    logic [`EX_IMM_W-1:0]  imm_in;
    logic [`EX_CSR_W-1:0]  csr_addr_in;
    logic [`EX_REG_W-1:0]  rd_in;
    logic                  asrc_pc_in;
    ex_pkg::bsrc_t         bsrc_in;
    ex_pkg::alu_ctrl_u     alu_ctrl_in;
    ex_pkg::branch_t       branch_in;
    logic [2:0]            mem_op_in;
    logic                  mem_rd_in, mem_wr_in, reg_wr_in, csr_in;
    logic                  ecall_in, mret_in, done_in;
    logic                  valid;
    logic [`EX_XLEN-1:0]   result;
    logic [`EX_XLEN-1:0]   next_pc;
    logic [`EX_XLEN-1:0]   pc;
    logic [`EX_XLEN-1:0]   store_data;
    logic [`EX_CSR_W-1:0]  csr_addr;
    logic [`EX_REG_W-1:0]  rd;
    logic [2:0]            mem_op;
    logic                  mem_rd, mem_wr, reg_wr, csr, ecall, mret, done;
    logic                  is_ex, is_jmp, error;

    // Reference copy of the stage register.
    logic                  check_en = 1'b0;
    logic                  m_valid;
    logic                  m_error;
    logic [`EX_XLEN-1:0]   m_src1, m_src2, m_csr_data, m_pc;
    logic [`EX_IMM_W-1:0]  m_imm;
    logic                  m_asrc_pc;
    ex_pkg::bsrc_t         m_bsrc;
    ex_pkg::alu_ctrl_u     m_ctrl;
    ex_pkg::branch_t       m_branch;
    logic                  m_mem_rd, m_csr, m_ecall;
    logic [26:0]           m_fields;
    logic [`EX_XLEN-1:0]   e_imm, e_op_a, e_op_b, e_alu;
    logic                  e_taken;
    logic [`EX_XLEN-1:0]   exp_result, exp_next_pc;
    logic                  exp_valid, exp_is_ex, exp_is_jmp, exp_error;
    int                    errors = 0;
    int                    n_stall;

    ex_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [63:0] alu_model(input ex_pkg::alu_op_t op, input logic word,
                                              input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        logic [31:0] rw;
        case (op)
            ex_pkg::ALU_ADD:    r = a + b;
            ex_pkg::ALU_SUB:    r = a - b;
            ex_pkg::ALU_SLL:    r = a << b[5:0];
            ex_pkg::ALU_SLT:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ex_pkg::ALU_SLTU:   r = (a < b) ? 64'd1 : 64'd0;
            ex_pkg::ALU_XOR:    r = a ^ b;
            ex_pkg::ALU_SRL:    r = a >> b[5:0];
            ex_pkg::ALU_SRA:    r = $signed(a) >>> b[5:0];
            ex_pkg::ALU_OR:     r = a | b;
            ex_pkg::ALU_AND:    r = a & b;
            ex_pkg::ALU_PASS_B: r = b;
            default:            r = 64'd0;
        endcase
        if (word) begin
            // Only the arithmetic and shift ops have true word forms.
            case (op)
                ex_pkg::ALU_ADD: rw = a[31:0] + b[31:0];
                ex_pkg::ALU_SUB: rw = a[31:0] - b[31:0];
                ex_pkg::ALU_SLL: rw = a[31:0] << b[4:0];
                ex_pkg::ALU_SRL: rw = a[31:0] >> b[4:0];
                ex_pkg::ALU_SRA: rw = $signed(a[31:0]) >>> b[4:0];
                default:         rw = r[31:0];
            endcase
            r = {{32{rw[31]}}, rw};
        end
        return r;
    endfunction

    // The signed high halves follow from the unsigned one minus operand corrections.
    function automatic logic [63:0] mul_model(input ex_pkg::md_op_t op, input logic word,
                                              input logic [63:0] a, input logic [63:0] b);
        logic [127:0] p;
        logic [63:0]  fix_a;
        logic [63:0]  fix_b;
        p     = {64'd0, a} * {64'd0, b};
        fix_a = a[63] ? b : 64'd0;
        fix_b = b[63] ? a : 64'd0;
        case (op)
            ex_pkg::MD_MUL:    return word ? {{32{p[31]}}, p[31:0]} : p[63:0];
            ex_pkg::MD_MULH:   return p[127:64] - fix_a - fix_b;
            ex_pkg::MD_MULHSU: return p[127:64] - fix_a;
            default:           return p[127:64];
        endcase
    endfunction

    function automatic logic branch_taken(input ex_pkg::branch_t br, input logic [63:0] r);
        case (br)
            ex_pkg::BR_JAL, ex_pkg::BR_JALR: return 1'b1;
            ex_pkg::BR_BEQ:                  return r == 64'd0;
            ex_pkg::BR_BNE:                  return r != 64'd0;
            ex_pkg::BR_BLT:                  return r[0];
            ex_pkg::BR_BGE:                  return !r[0];
            default:                         return 1'b0;
        endcase
    endfunction

    always @(posedge clk) begin
        check_en <= 1'b1;
        if (rst) begin
            m_valid <= 1'b0;
        end else if (!block) begin
            m_valid <= valid_in;
        end
        if (!block) begin
            m_error    <= error_in;
            m_src1     <= src1_in;
            m_src2     <= src2_in;
            m_csr_data <= csr_data_in;
            m_pc       <= pc_in;
            m_imm      <= imm_in;
            m_asrc_pc  <= asrc_pc_in;
            m_bsrc     <= bsrc_in;
            m_ctrl     <= alu_ctrl_in;
            m_branch   <= branch_in;
            m_mem_rd   <= mem_rd_in;
            m_csr      <= csr_in;
            m_ecall    <= ecall_in;
            m_fields   <= {csr_addr_in, rd_in, mem_op_in, mem_rd_in, mem_wr_in, reg_wr_in,
                           csr_in, ecall_in, mret_in, done_in};
        end
    end

    always_comb begin
        e_imm  = {{(`EX_XLEN-`EX_IMM_W){m_imm[`EX_IMM_W-1]}}, m_imm};
        e_op_a = m_asrc_pc ? m_pc : m_src1;
        case (m_bsrc)
            ex_pkg::BSRC_SRC2: e_op_b = m_src2;
            ex_pkg::BSRC_FOUR: e_op_b = 64'd4;
            ex_pkg::BSRC_IMM:  e_op_b = e_imm;
            default:           e_op_b = m_csr_data;
        endcase
        e_alu = alu_model(m_ctrl.alu.op, m_ctrl.alu.word, e_op_a, e_op_b);
        if (!m_ctrl.md.muldiv) begin
            exp_result = e_alu;
        end else if (m_ctrl.md.div) begin
            exp_result = 64'd0;
        end else begin
            exp_result = mul_model(m_ctrl.md.op, m_ctrl.md.word, m_src1, m_src2);
        end
        e_taken = branch_taken(m_branch, e_alu);
        if (e_taken && m_branch == ex_pkg::BR_JALR) begin
            exp_next_pc = (m_src1 + e_imm) & ~64'd1;
        end else if (e_taken) begin
            exp_next_pc = m_pc + e_imm;
        end else begin
            exp_next_pc = m_pc + 64'd4;
        end
        exp_is_jmp = m_valid && (e_taken || m_csr);
        exp_is_ex  = !m_mem_rd && !(m_ctrl.md.muldiv && !m_ctrl.md.div);
        exp_error  = m_error || (m_ctrl.md.muldiv && m_ctrl.md.div);
    end

    assign exp_valid = m_valid && (m_ecall || !raise_intr);   // Sees raise_intr live.

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors = errors + 1;
        $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
    endtask

    chk_valid: assert property (@(posedge clk) check_en |-> valid === exp_valid)
        else report_mismatch("valid", 64'($sampled(valid)), 64'($sampled(exp_valid)));
    chk_result: assert property (@(posedge clk) check_en |-> result === exp_result)
        else report_mismatch("result", $sampled(result), $sampled(exp_result));
    chk_next_pc: assert property (@(posedge clk) check_en |-> next_pc === exp_next_pc)
        else report_mismatch("next_pc", $sampled(next_pc), $sampled(exp_next_pc));
    chk_is_jmp: assert property (@(posedge clk) check_en |-> is_jmp === exp_is_jmp)
        else report_mismatch("is_jmp", 64'($sampled(is_jmp)), 64'($sampled(exp_is_jmp)));
    chk_is_ex: assert property (@(posedge clk) check_en |-> is_ex === exp_is_ex)
        else report_mismatch("is_ex", 64'($sampled(is_ex)), 64'($sampled(exp_is_ex)));
    chk_error: assert property (@(posedge clk) check_en |-> error === exp_error)
        else report_mismatch("error", 64'($sampled(error)), 64'($sampled(exp_error)));
    chk_pc: assert property (@(posedge clk) check_en |-> pc === m_pc)
        else report_mismatch("pc", $sampled(pc), $sampled(m_pc));
    chk_store_data: assert property (@(posedge clk) check_en |-> store_data === m_src2)
        else report_mismatch("store_data", $sampled(store_data), $sampled(m_src2));
    chk_fields: assert property (@(posedge clk) check_en |->
        {csr_addr, rd, mem_op, mem_rd, mem_wr, reg_wr, csr, ecall, mret, done} === m_fields)
        else report_mismatch("passthrough fields", 64'($sampled({csr_addr, rd, mem_op,
            mem_rd, mem_wr, reg_wr, csr, ecall, mret, done})), 64'($sampled(m_fields)));
    chk_stall: assert property (@(posedge clk) (check_en && block) |=>
        ($stable(result) && $stable(next_pc) && $stable(store_data) && $stable(rd) &&
         $stable(is_jmp) && $stable(is_ex) && $stable(error) && $stable(valid) &&
         $stable(pc) &&
         $stable({csr_addr, mem_op, mem_rd, mem_wr, reg_wr, csr, ecall, mret, done})))
        else begin
            errors = errors + 1;
            $display("outputs changed while block was held high");
        end

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic random_instr();
        valid_in    = 1'b1;
        block       = 1'b0;
        error_in    = 1'b0;
        raise_intr  = 1'b0;
        src1_in     = {$urandom, $urandom};
        src2_in     = {$urandom, $urandom};
        csr_data_in = {$urandom, $urandom};
        pc_in       = {$urandom, 30'($urandom), 2'b00};
        imm_in      = $urandom;
        csr_addr_in = 12'($urandom);
        rd_in       = 5'($urandom);
        mem_op_in   = 3'($urandom);
        mem_rd_in   = 1'b0;
        mem_wr_in   = 1'($urandom);
        reg_wr_in   = 1'($urandom);
        csr_in      = 1'b0;
        ecall_in    = 1'b0;
        mret_in     = 1'($urandom);
        done_in     = 1'($urandom);
        asrc_pc_in  = 1'b0;
        bsrc_in     = ex_pkg::BSRC_SRC2;
        alu_ctrl_in = '0;
        branch_in   = ex_pkg::BR_NONE;
    endtask

    task automatic set_alu(input ex_pkg::alu_op_t op, input logic word);
        alu_ctrl_in          = '0;
        alu_ctrl_in.alu.word = word;
        alu_ctrl_in.alu.op   = op;
    endtask

    task automatic set_md(input ex_pkg::md_op_t op, input logic word, input logic div);
        alu_ctrl_in           = '0;
        alu_ctrl_in.md.muldiv = 1'b1;
        alu_ctrl_in.md.word   = word;
        alu_ctrl_in.md.div    = div;
        alu_ctrl_in.md.op     = op;
    endtask

    task automatic wait_for_valid(input int limit);
        int n;
        n = 0;
        while (valid !== 1'b1 && n < limit) begin
            step();
            n = n + 1;
        end
        if (valid !== 1'b1) begin
            errors = errors + 1;
            $display("timeout: valid did not rise within %0d cycles", limit);
        end
    endtask

    initial begin
        void'($urandom(92));
        rst = 1'b1;
        random_instr();
        branch_in = ex_pkg::BR_JAL;    // A jump must stay hidden during reset.
        csr_in    = 1'b1;
        repeat (16) @(posedge clk);
        #5;
        rst      = 1'b0;
        valid_in = 1'b0;
        step();
        step();
        random_instr();
        wait_for_valid(4);

        for (int k = 0; k <= 10; k++) begin
            for (int s = 0; s < 4; s++) begin
                for (int a = 0; a < 2; a++) begin
                    for (int w = 0; w < 2; w++) begin
                        random_instr();
                        set_alu(ex_pkg::alu_op_t'(k), 1'(w));
                        bsrc_in    = ex_pkg::bsrc_t'(s);
                        asrc_pc_in = 1'(a);
                        mem_rd_in  = 1'($urandom);
                        step();
                    end
                end
            end
        end

        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                random_instr();
                set_md(ex_pkg::md_op_t'(k), 1'b0, 1'b0);
                step();
            end
            random_instr();
            set_md(ex_pkg::MD_MUL, 1'b1, 1'b0);
            step();
        end
        random_instr();
        set_md(ex_pkg::MD_MUL, 1'b0, 1'b1);
        step();
        random_instr();
        error_in = 1'b1;
        step();

        random_instr();
        branch_in = ex_pkg::BR_JAL;
        step();
        random_instr();
        branch_in = ex_pkg::BR_JALR;
        imm_in    = imm_in | 32'd1;    // Odd target so bit 0 must be cleared.
        step();
        for (int b = 4; b < 8; b++) begin
            for (int t = 0; t < 2; t++) begin
                random_instr();
                branch_in = ex_pkg::branch_t'(b);
                set_alu((b < 6) ? ex_pkg::ALU_SUB : ex_pkg::ALU_SLTU, 1'b0);
                src2_in   = src1_in + 64'(t);
                step();
            end
        end
        random_instr();
        csr_in = 1'b1;
        step();
        random_instr();
        branch_in = ex_pkg::BR_JAL;
        valid_in  = 1'b0;
        step();

        for (int r = 0; r < 4; r++) begin
            random_instr();
            set_alu(ex_pkg::alu_op_t'($urandom % 11), 1'($urandom));
            step();
            n_stall = 1 + int'($urandom % 8);
            for (int c = 0; c < n_stall; c++) begin
                random_instr();
                block = 1'b1;
                step();
            end
            random_instr();
            step();
        end

        for (int r = 0; r < 8; r++) begin
            random_instr();
            raise_intr = 1'b1;
            ecall_in   = 1'($urandom);
            step();
        end
        random_instr();
        step();
        step();

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_unit_if.sv
verilog/ex_alu.sv
verilog/ex_muldiv.sv
verilog/ex_next_pc.sv
verilog/ex_stage.sv
verilog/ex_top.sv
tb/ex_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := ex_tb
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP)
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED
PASS_MSG   := ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
